//--- hdl/store_geom_pkg.sv
// ======================================
// word, beat, address and length widths
// of the store path
// ======================================
`default_nettype none

package store_geom_pkg;

    // result word pushed by the compute logic
    localparam int word_w = 32;

    // one entry of the write master user buffer
    localparam int beat_w = 128;

    // words packed into one beat
    localparam int words_per_beat = beat_w / word_w;

    // byte address on the master side
    localparam int addr_w = 32;

    // job length, counted in words
    localparam int len_w = 12;

    // burst length given to the master, in bytes
    localparam int cmd_len_w = 8;

endpackage

`default_nettype wire

//--- hdl/store_state_pkg.sv
// ======================================
// FSM state encodings of the store path
// ======================================
`default_nettype none

package store_state_pkg;

    // job controller
    typedef enum logic [1:0] {
        idle,
        run,
        finish
    } ctrl_state_e;

    // burst issuer
    typedef enum logic [1:0] {
        wait_data,
        issue,
        wait_done,
        settle
    } issue_state_e;

endpackage

`default_nettype wire

//--- hdl/store_job_if.sv
// ======================================
// store job handoff from the controller
// to the packer and the burst issuer
// ======================================
`default_nettype none
`timescale 1ns/100ps

interface store_job_if;

    // one-cycle pulse at the start of a job
    logic                               start;
    // byte base address and length in words, held for the whole job
    logic [store_geom_pkg::addr_w-1:0]  base;
    logic [store_geom_pkg::len_w-1:0]   len_words;
    // one-cycle pulse once the last burst has completed
    logic                               done;

    modport ctrl (
        output start,
        output base,
        output len_words,
        input  done
    );

    modport worker (
        input  start,
        input  base,
        input  len_words,
        output done
    );

endinterface

`default_nettype wire

//--- hdl/word_fifo.sv
// ======================================
// show-ahead FIFO of result words
// ======================================
`default_nettype none
`timescale 1ns/100ps

module word_fifo #(
    parameter int fifo_depth = 16
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 push,
    input  wire [store_geom_pkg::word_w-1:0]    push_data,
    output logic                                full,
    input  wire                                 pop,
    output logic [store_geom_pkg::word_w-1:0]   rd_data,
    output logic                                empty
);

    localparam int pw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cw = $clog2(fifo_depth + 1);
    localparam logic [pw-1:0] last_ptr = pw'(fifo_depth - 1);
    localparam logic [cw-1:0] depth_cnt = cw'(fifo_depth);

    logic [store_geom_pkg::word_w-1:0] mem [fifo_depth];
    logic [pw-1:0] wr_ptr;
    logic [pw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic          do_push;
    logic          do_pop;

    // a push into a full FIFO is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full    = (count == depth_cnt);
    assign empty   = (count == '0);
    // head word is visible before the pop
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/store_ctrl.sv
// ======================================
// store job controller, start strobe to
// done pulse
// ======================================
`default_nettype none
`timescale 1ns/100ps

module store_ctrl (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 store_start,
    input  wire [store_geom_pkg::addr_w-1:0]    param_waddr,
    input  wire [store_geom_pkg::len_w-1:0]     param_iolen,
    store_job_if.ctrl                           job,
    output logic                                store_done
);

    store_state_pkg::ctrl_state_e state;

    logic                               start_q;
    logic [store_geom_pkg::addr_w-1:0]  base_q;
    logic [store_geom_pkg::len_w-1:0]   len_q;
    logic                               accept;

    // starts are only taken between jobs
    assign accept = (state == store_state_pkg::idle) && store_start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= store_state_pkg::idle;
            start_q <= 1'b0;
        end else begin
            start_q <= accept;
            case (state)
                store_state_pkg::idle: begin
                    if (accept) begin
                        state <= store_state_pkg::run;
                    end
                end
                store_state_pkg::run: begin
                    // issuer reports the last burst complete
                    if (job.done) begin
                        state <= store_state_pkg::finish;
                    end
                end
                default: begin
                    state <= store_state_pkg::idle;
                end
            endcase
        end
    end

    // job parameters stay fixed until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            base_q <= param_waddr;
            len_q  <= param_iolen;
        end
    end

    assign job.start     = start_q;
    assign job.base      = base_q;
    assign job.len_words = len_q;
    assign store_done    = (state == store_state_pkg::finish);

endmodule

`default_nettype wire

//--- hdl/beat_packer.sv
// ======================================
// packs popped words into 128-bit beats
// for the write master user buffer
// ======================================
`default_nettype none
`timescale 1ns/100ps

module beat_packer (
    input  wire                                 clk,
    input  wire                                 rst,
    store_job_if.worker                         job,
    output logic                                pop,
    input  wire [store_geom_pkg::word_w-1:0]    rd_data,
    input  wire                                 empty,
    output logic [store_geom_pkg::beat_w-1:0]   wmst_user_write_data,
    output logic                                wmst_user_write_buffer,
    input  wire                                 wmst_user_buffer_full,
    output logic                                beat_written
);

    localparam int wpb = store_geom_pkg::words_per_beat;
    localparam int ww  = store_geom_pkg::word_w;
    localparam int bw  = store_geom_pkg::beat_w;

    logic [store_geom_pkg::len_w-1:0] words_left;
    logic [wpb-1:0] lane;
    logic [wpb-1:0] lane_d1;
    logic [wpb-1:0] lane_d2;
    logic [ww-1:0]  data_d1;
    logic [ww-1:0]  data_d2;
    logic [bw-1:0]  beat_sr;
    logic [bw-1:0]  beat_next;
    logic           beat_done;
    logic           pending;

    assign pop = (words_left != '0) && !empty && !wmst_user_buffer_full;

    // ======================================
    // pop side
    // ======================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            words_left <= '0;
            lane       <= wpb'(1);
        end else if (job.start) begin
            words_left <= job.len_words;
            lane       <= wpb'(1);
        end else if (pop) begin
            words_left <= words_left - 1'b1;
            lane       <= {lane[wpb-2:0], lane[wpb-1]};
        end
    end

    // lane marks and words travel two cycles to the beat register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lane_d1 <= '0;
            lane_d2 <= '0;
        end else begin
            lane_d1 <= pop ? lane : '0;
            lane_d2 <= lane_d1;
        end
    end

    always_ff @(posedge clk) begin
        data_d1 <= rd_data;
        data_d2 <= data_d1;
    end

    // ======================================
    // beat assembly and buffer write
    // ======================================
    // newest word enters at the top, first word ends in the low lane
    assign beat_next = {data_d2, beat_sr[bw-1:ww]};
    assign beat_done = lane_d2[wpb-1];

    always_ff @(posedge clk) begin
        if (|lane_d2) begin
            beat_sr <= beat_next;
        end
        if (beat_done) begin
            wmst_user_write_data <= beat_next;
        end
    end

    // a finished beat that meets buffer_full waits here until it drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wmst_user_write_buffer <= 1'b0;
            pending                <= 1'b0;
        end else begin
            wmst_user_write_buffer <= (beat_done || pending) && !wmst_user_buffer_full;
            if (beat_done && wmst_user_buffer_full) begin
                pending <= 1'b1;
            end else if (!wmst_user_buffer_full) begin
                pending <= 1'b0;
            end
        end
    end

    assign beat_written = wmst_user_write_buffer;

endmodule

`default_nettype wire

//--- hdl/burst_issuer.sv
// ======================================
// burst command issue to the write master
// ======================================
`default_nettype none
`timescale 1ns/100ps

module burst_issuer #(
    parameter int burst_words = 8
) (
    input  wire                                     clk,
    input  wire                                     rst,
    store_job_if.worker                             job,
    input  wire                                     beat_written,
    output logic [store_geom_pkg::addr_w-1:0]       wmst_write_base,
    output logic [store_geom_pkg::cmd_len_w-1:0]    wmst_write_length,
    output logic                                    wmst_go,
    input  wire                                     wmst_done
);

    localparam int lw = store_geom_pkg::len_w;
    localparam int aw = store_geom_pkg::addr_w;
    localparam logic [lw-1:0] burst_len = burst_words[lw-1:0];
    localparam logic [lw-1:0] beat_len = lw'(store_geom_pkg::words_per_beat);

    store_state_pkg::issue_state_e state;

    logic [lw-1:0]   recv_cnt;
    logic [lw-1:0]   cmd_cnt;
    logic [lw-1:0]   remain_cnt;
    logic [lw-1:0]   avail;
    logic [lw-1:0]   cmd_words;
    logic [lw+1:0]   cmd_bytes;
    logic [aw-1:0]   next_base;
    logic            done_d;
    logic            done_edge;
    logic            master_idle;
    logic            data_ready;
    logic            last_burst;

    // ======================================
    // master status and data accounting
    // ======================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_d <= 1'b0;
        end else begin
            done_d <= wmst_done;
        end
    end

    assign done_edge   = wmst_done && !done_d;
    // first cycle of a done rise does not count as idle
    assign master_idle = wmst_done && !done_edge;

    // words sitting in the master buffer without a command yet
    assign avail      = recv_cnt - cmd_cnt;
    assign data_ready = (remain_cnt != '0) && ((avail >= burst_len) || (avail >= remain_cnt));
    assign cmd_words  = (remain_cnt > burst_len) ? burst_len : remain_cnt;
    assign cmd_bytes  = {cmd_words, 2'b00};
    assign last_burst = (remain_cnt == '0);

    // ======================================
    // command FSM
    // ======================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= store_state_pkg::wait_data;
        end else begin
            case (state)
                store_state_pkg::wait_data: begin
                    if (data_ready && master_idle) begin
                        state <= store_state_pkg::issue;
                    end
                end
                store_state_pkg::issue: begin
                    state <= store_state_pkg::wait_done;
                end
                store_state_pkg::wait_done: begin
                    // done falls after go, the next rise ends the burst
                    if (done_edge) begin
                        state <= store_state_pkg::settle;
                    end
                end
                default: begin
                    state <= store_state_pkg::wait_data;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            recv_cnt   <= '0;
            cmd_cnt    <= '0;
            remain_cnt <= '0;
            next_base  <= '0;
        end else if (job.start) begin
            recv_cnt   <= '0;
            cmd_cnt    <= '0;
            remain_cnt <= job.len_words;
            next_base  <= job.base;
        end else if (state == store_state_pkg::settle && last_burst) begin
            recv_cnt <= '0;
            cmd_cnt  <= '0;
        end else begin
            if (beat_written) begin
                recv_cnt <= recv_cnt + beat_len;
            end
            if (state == store_state_pkg::issue) begin
                cmd_cnt    <= cmd_cnt + cmd_words;
                remain_cnt <= remain_cnt - cmd_words;
                next_base  <= next_base + {{(aw-lw-2){1'b0}}, cmd_bytes};
            end
        end
    end

    assign wmst_go           = (state == store_state_pkg::issue);
    assign wmst_write_base   = next_base;
    assign wmst_write_length = cmd_bytes[store_geom_pkg::cmd_len_w-1:0];

    // remain is already zero once the final go has been given
    assign job.done = (state == store_state_pkg::wait_done) && done_edge && last_burst;

endmodule

`default_nettype wire

//--- hdl/store_tile.sv
// ======================================
// store path top level with word FIFO,
// controller, beat packer and burst issuer
// ======================================
`default_nettype none
`timescale 1ns/100ps

module store_tile #(
    parameter int burst_words = 8,
    parameter int fifo_depth  = 16
) (
    input  wire                                     clk,
    input  wire                                     rst,
    // compute side
    input  wire [store_geom_pkg::word_w-1:0]        word_data,
    input  wire                                     word_push,
    output wire                                     word_full,
    // configuration side
    input  wire                                     store_start,
    input  wire [store_geom_pkg::addr_w-1:0]        param_waddr,
    input  wire [store_geom_pkg::len_w-1:0]         param_iolen,
    output wire                                     store_done,
    // write master command
    output wire [store_geom_pkg::addr_w-1:0]        wmst_write_base,
    output wire [store_geom_pkg::cmd_len_w-1:0]     wmst_write_length,
    output wire                                     wmst_go,
    input  wire                                     wmst_done,
    // write master user buffer
    output wire [store_geom_pkg::beat_w-1:0]        wmst_user_write_data,
    output wire                                     wmst_user_write_buffer,
    input  wire                                     wmst_user_buffer_full
);

    wire                                pop;
    wire [store_geom_pkg::word_w-1:0]   word_rd;
    wire                                empty;
    wire                                beat_written;

    store_job_if job ();

    word_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (word_push),
        .push_data (word_data),
        .full      (word_full),
        .pop       (pop),
        .rd_data   (word_rd),
        .empty     (empty)
    );

    store_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .store_start (store_start),
        .param_waddr (param_waddr),
        .param_iolen (param_iolen),
        .job         (job.ctrl),
        .store_done  (store_done)
    );

    beat_packer u_packer (
        .clk                    (clk),
        .rst                    (rst),
        .job                    (job.worker),
        .pop                    (pop),
        .rd_data                (word_rd),
        .empty                  (empty),
        .wmst_user_write_data   (wmst_user_write_data),
        .wmst_user_write_buffer (wmst_user_write_buffer),
        .wmst_user_buffer_full  (wmst_user_buffer_full),
        .beat_written           (beat_written)
    );

    burst_issuer #(
        .burst_words (burst_words)
    ) u_issuer (
        .clk               (clk),
        .rst               (rst),
        .job               (job.worker),
        .beat_written      (beat_written),
        .wmst_write_base   (wmst_write_base),
        .wmst_write_length (wmst_write_length),
        .wmst_go           (wmst_go),
        .wmst_done         (wmst_done)
    );

endmodule

`default_nettype wire

//--- testbench/store_checker.sv
// ========================================
// store path checker for expected commands,
// memory image and done pulses
// ========================================
`default_nettype none
`timescale 1ns/100ps

module store_checker #(
    parameter int burst_words = 8
) (
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire [store_geom_pkg::word_w-1:0]        word_data,
    input  wire                                     word_push,
    input  wire                                     word_full,
    input  wire                                     store_start,
    input  wire [store_geom_pkg::addr_w-1:0]        param_waddr,
    input  wire [store_geom_pkg::len_w-1:0]         param_iolen,
    input  wire                                     store_done,
    input  wire [store_geom_pkg::addr_w-1:0]        wmst_write_base,
    input  wire [store_geom_pkg::cmd_len_w-1:0]     wmst_write_length,
    input  wire                                     wmst_go,
    input  wire                                     wmst_done,
    input  wire                                     wmst_user_write_buffer,
    // beats as the master model lands them
    input  wire                                     mem_we,
    input  wire [31:0]                              mem_addr,
    input  wire [store_geom_pkg::beat_w-1:0]        mem_beat,
    output int                                      errors,
    output int                                      checks,
    output int                                      done_count
);

    logic [31:0] exp_base_q [$];
    int          exp_len_q [$];
    logic [31:0] exp_mem [logic [31:0]];

    logic        busy;
    logic        started;
    logic        done_prev;
    logic [31:0] job_base;
    int          job_len;
    int          word_idx;
    int          cyc;
    int          rise_cyc;

    // full bursts of burst_words and a shorter tail with the base stepping by length
    function automatic void expect_commands(input logic [31:0] base, input int len_words);
        int          left;
        int          n;
        logic [31:0] addr;
        left = len_words;
        addr = base;
        while (left > 0) begin
            n = (left > burst_words) ? burst_words : left;
            exp_base_q.push_back(addr);
            exp_len_q.push_back(n * 4);
            addr = addr + 32'(n * 4);
            left = left - n;
        end
    endfunction

    task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expv, actv);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR time=%0t %s", $time, msg);
    endtask

    always @(posedge clk) begin
        logic [31:0] a;
        if (rst) begin
            errors = 0;
            checks = 0;
            done_count = 0;
            busy = 1'b0;
            started = 1'b0;
            done_prev = 1'b1;
            word_idx = 0;
            job_len = 0;
            cyc = 0;
            rise_cyc = -10;
        end else begin
            cyc++;
            if (!started && (wmst_go || wmst_user_write_buffer || store_done || word_full)) begin
                report_problem("DUT output active before the first job");
            end
            // a strobe during a job is ignored
            if (store_start && !busy) begin
                busy = 1'b1;
                started = 1'b1;
                job_base = param_waddr;
                job_len = int'(param_iolen);
                word_idx = 0;
                expect_commands(param_waddr, int'(param_iolen));
            end
            if (word_push && !word_full) begin
                if (!busy || word_idx >= job_len) begin
                    report_problem("word pushed outside a running job");
                end else begin
                    exp_mem[job_base + 32'(4 * word_idx)] = word_data;
                    word_idx++;
                end
            end
            if (wmst_done && !done_prev) begin
                rise_cyc = cyc;
            end
            done_prev = wmst_done;
            if (wmst_go) begin
                if (!wmst_done) begin
                    report_problem("go issued while wmst_done was low");
                end
                if (exp_base_q.size() == 0) begin
                    report_problem("go issued with no command expected");
                end else begin
                    compare("wmst_write_base", exp_base_q.pop_front(), wmst_write_base);
                    compare("wmst_write_length", exp_len_q.pop_front(), 32'(wmst_write_length));
                end
            end
            if (mem_we) begin
                for (int i = 0; i < 4; i++) begin
                    a = mem_addr + 32'(4 * i);
                    if (!exp_mem.exists(a)) begin
                        report_problem($sformatf("unexpected or repeated write at %h", a));
                    end else begin
                        compare($sformatf("mem[%h]", a), exp_mem[a], mem_beat[32*i +: 32]);
                        exp_mem.delete(a);
                    end
                end
            end
            if (store_done) begin
                done_count++;
                if (!busy) begin
                    report_problem("store_done pulsed with no job running");
                end
                if (cyc != rise_cyc + 1) begin
                    report_problem("store_done not one cycle after the wmst_done rise");
                end
                if (exp_base_q.size() != 0) begin
                    report_problem("store_done before all burst commands were issued");
                end
                if (exp_mem.size() != 0) begin
                    report_problem("store_done with words never written to memory");
                end
                busy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_store_tile.sv
// ========================================
// store tile testbench with clock, reset,
// LFSR, stimulus, write master model and watchdog
// ========================================
`default_nettype none
`timescale 1ns/100ps

module tb_store_tile;

    localparam int burst_words = 8;
    localparam int fifo_depth  = 16;
    localparam int n_jobs      = 5;
    // sum of the lengths of all jobs below
    localparam int total_words = 112;

    logic                                   clk;
    logic                                   rst;
    logic [store_geom_pkg::word_w-1:0]      word_data = '0;
    logic                                   word_push = 1'b0;
    wire                                    word_full;
    logic                                   store_start;
    logic [store_geom_pkg::addr_w-1:0]      param_waddr;
    logic [store_geom_pkg::len_w-1:0]       param_iolen;
    wire                                    store_done;
    wire [store_geom_pkg::addr_w-1:0]       wmst_write_base;
    wire [store_geom_pkg::cmd_len_w-1:0]    wmst_write_length;
    wire                                    wmst_go;
    logic                                   wmst_done = 1'b1;
    wire [store_geom_pkg::beat_w-1:0]       wmst_user_write_data;
    wire                                    wmst_user_write_buffer;
    logic                                   wmst_user_buffer_full = 1'b0;

    // landed beats for the checker
    logic                                   mem_we = 1'b0;
    logic [31:0]                            mem_addr = '0;
    logic [store_geom_pkg::beat_w-1:0]      mem_beat = '0;

    // job requests from the main sequence
    int   words_requested;
    logic bp_on;

    // owned by the bus driver process
    logic [15:0]  lfsr = 16'd40;
    int           pushed_count = 0;
    int           model_errors = 0;
    logic [127:0] beat_q [$];
    logic         dropping = 1'b0;
    logic         draining = 1'b0;
    int           drain_left = 0;
    logic [31:0]  drain_addr = '0;

    int chk_errors;
    int chk_checks;
    int done_count;

    store_tile #(
        .burst_words (burst_words),
        .fifo_depth  (fifo_depth)
    ) UUT (
        .clk                    (clk),
        .rst                    (rst),
        .word_data              (word_data),
        .word_push              (word_push),
        .word_full              (word_full),
        .store_start            (store_start),
        .param_waddr            (param_waddr),
        .param_iolen            (param_iolen),
        .store_done             (store_done),
        .wmst_write_base        (wmst_write_base),
        .wmst_write_length      (wmst_write_length),
        .wmst_go                (wmst_go),
        .wmst_done              (wmst_done),
        .wmst_user_write_data   (wmst_user_write_data),
        .wmst_user_write_buffer (wmst_user_write_buffer),
        .wmst_user_buffer_full  (wmst_user_buffer_full)
    );

    store_checker #(
        .burst_words (burst_words)
    ) u_checker (
        .clk                    (clk),
        .rst                    (rst),
        .word_data              (word_data),
        .word_push              (word_push),
        .word_full              (word_full),
        .store_start            (store_start),
        .param_waddr            (param_waddr),
        .param_iolen            (param_iolen),
        .store_done             (store_done),
        .wmst_write_base        (wmst_write_base),
        .wmst_write_length      (wmst_write_length),
        .wmst_go                (wmst_go),
        .wmst_done              (wmst_done),
        .wmst_user_write_buffer (wmst_user_write_buffer),
        .mem_we                 (mem_we),
        .mem_addr               (mem_addr),
        .mem_beat               (mem_beat),
        .errors                 (chk_errors),
        .checks                 (chk_checks),
        .done_count             (done_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // ========================================
    // compute source and write master model
    // ========================================
    always @(negedge clk) begin
        logic [127:0] beat;
        mem_we = 1'b0;
        word_push = 1'b0;
        if (!rst) begin
            if (pushed_count < words_requested && !word_full &&
                (!bp_on || take_bits(1) == 32'd1)) begin
                word_push = 1'b1;
                word_data = take_bits(32);
                pushed_count++;
            end
            if (wmst_user_write_buffer) begin
                beat_q.push_back(wmst_user_write_data);
                if (beat_q.size() > 8) begin
                    model_errors++;
                    $display("ERROR time=%0t master user buffer overflowed", $time);
                end
            end
            if (draining) begin
                if (beat_q.size() == 0) begin
                    model_errors++;
                    $display("ERROR time=%0t burst started without its data", $time);
                    draining = 1'b0;
                    wmst_done = 1'b1;
                end else if (!bp_on || take_bits(1) == 32'd1) begin
                    beat = beat_q.pop_front();
                    mem_we = 1'b1;
                    mem_addr = drain_addr;
                    mem_beat = beat;
                    drain_addr = drain_addr + 32'd16;
                    drain_left--;
                    if (drain_left == 0) begin
                        draining = 1'b0;
                        wmst_done = 1'b1;
                    end
                end
            end else if (dropping) begin
                wmst_done = 1'b0;
                dropping = 1'b0;
                draining = 1'b1;
            end else if (wmst_go) begin
                drain_addr = wmst_write_base;
                drain_left = int'(wmst_write_length) / 16;
                dropping = 1'b1;
            end
            wmst_user_buffer_full = (beat_q.size() >= 6) || (bp_on && take_bits(2) == 32'd0);
        end
    end

    // ========================================
    // job sequence
    // ========================================
    task automatic pulse_start(input logic [31:0] base, input logic [11:0] len);
        @(negedge clk);
        store_start = 1'b1;
        param_waddr = base;
        param_iolen = len;
        @(negedge clk);
        store_start = 1'b0;
    endtask

    task automatic run_job(input logic [31:0] base, input int n, input logic random_mode);
        pulse_start(base, 12'(n));
        @(posedge clk);
        bp_on = random_mode;
        words_requested = words_requested + n;
    endtask

    task automatic wait_store_done();
        @(negedge clk);
        while (!store_done) begin
            @(negedge clk);
        end
    endtask

    initial begin
        rst = 1'b1;
        store_start = 1'b0;
        param_waddr = '0;
        param_iolen = '0;
        words_requested = 0;
        bp_on = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        // quiet period after reset
        repeat (20) @(negedge clk);
        run_job(32'h0000_1000, 16, 1'b0);
        wait_store_done();
        // tail burst of four words
        run_job(32'h0000_2000, 20, 1'b0);
        wait_store_done();
        run_job(32'h0000_3010, 40, 1'b1);
        wait_store_done();
        run_job(32'h0000_4000, 12, 1'b1);
        // this strobe lands while the job runs
        repeat (3) @(negedge clk);
        pulse_start(32'h0000_9000, 12'd8);
        wait_store_done();
        run_job(32'h0000_5000, 24, 1'b1);
        wait_store_done();
        repeat (20) @(negedge clk);
        $display("jobs=%0d checks=%0d errors=%0d model_errors=%0d",
                 done_count, chk_checks, chk_errors, model_errors);
        if (chk_errors == 0 && model_errors == 0 && done_count == n_jobs && chk_checks > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (total_words * 40 + 2000) @(posedge clk);
        $display("watchdog expired before all store jobs completed");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- store_tile.f
hdl/store_geom_pkg.sv
hdl/store_state_pkg.sv
hdl/store_job_if.sv
hdl/word_fifo.sv
hdl/store_ctrl.sv
hdl/beat_packer.sv
hdl/burst_issuer.sv
hdl/store_tile.sv
testbench/store_checker.sv
testbench/tb_store_tile.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall
TOP        = tb_store_tile
RTL_TOP    = store_tile
FLIST      = store_tile.f
OBJ_DIR    = obj_dir
LOG        = sim.log

SOURCES    = $(shell cat $(FLIST))
RTL_FILES  = $(filter hdl/%,$(SOURCES))
SIM_BIN    = $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
